/* design/cpu16_pkg.sv */
`default_nettype none

package cpu16_pkg;

	localparam int DATA_W = 16;
	localparam int REG_COUNT = 8;
	localparam int MEM_WORDS = 64;

	typedef logic [DATA_W-1:0] word_t;
	typedef logic [$clog2(REG_COUNT)-1:0] reg_idx_t;
	typedef logic [$clog2(MEM_WORDS)-1:0] mem_idx_t;

	// instruction fields
	localparam int OPC_LSB = 0;
	localparam int RA_LSB = 4; // first source and destination
	localparam int RB_LSB = 7;
	localparam int FUNC_LSB = 10;
	localparam int IMM_LSB = 10;
	localparam int IMM_W = 6;

	typedef enum logic [3:0] {
		OP_RTYPE = 4'd0,
		OP_LW = 4'd7,
		OP_SW = 4'd8,
		OP_BNE = 4'd9,
		OP_ORI = 4'd11,
		OP_HALT = 4'd15
	} opcode_t;

	typedef enum logic [2:0] {FN_ADD = 3'd1, FN_SUB = 3'd2} func_t;

	typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_OR} alu_op_t;

	typedef enum logic [1:0] {SRC_A_PC, SRC_A_REG, SRC_A_SEXT, SRC_A_ZEXT} alu_a_sel_t;

	typedef enum logic [1:0] {SRC_B_REG, SRC_B_TWO, SRC_B_BOFF} alu_b_sel_t;

	typedef enum logic [1:0] {PC_ALU, PC_BRANCH, PC_ZERO} pc_src_t;

	typedef enum logic {WB_ALU, WB_MEM} wb_sel_t;

	typedef enum logic [2:0] {
		S_IDLE, S_FETCH, S_DECODE, S_EXEC, S_MEMWB, S_LOADWB, S_HALTED
	} cpu_state_t;

	localparam word_t REG_RESET [REG_COUNT] = '{
		16'd7, 16'd8, 16'd20, 16'd32, 16'd1, 16'd5, 16'd1, 16'd6
	};

endpackage

`default_nettype wire

/* design/cpu_ctrl_if.sv */
`default_nettype none

interface cpu_ctrl_if;

	logic pc_write;
	logic ir_write;
	logic i_or_d; // 1 selects alu-out as address
	logic mem_read;
	logic mem_write;
	logic reg_write;
	cpu16_pkg::alu_op_t alu_op;
	cpu16_pkg::alu_a_sel_t a_sel;
	cpu16_pkg::alu_b_sel_t b_sel;
	cpu16_pkg::pc_src_t pc_src;
	cpu16_pkg::wb_sel_t wb_sel;
	logic branch;

	cpu16_pkg::opcode_t opcode;
	cpu16_pkg::func_t func;
	logic zero;

	modport ctrl (output pc_write, ir_write, i_or_d, mem_read, mem_write, reg_write,
		alu_op, a_sel, b_sel, pc_src, wb_sel, branch, input opcode, func, zero);

	modport dp (input pc_write, ir_write, i_or_d, mem_read, mem_write, reg_write,
		alu_op, a_sel, b_sel, pc_src, wb_sel, branch, output opcode, func, zero);

endinterface

`default_nettype wire

/* design/mem_bus_if.sv */
`default_nettype none

interface mem_bus_if;

	cpu16_pkg::word_t addr; // byte address
	cpu16_pkg::word_t wdata;
	logic read;
	logic write;
	cpu16_pkg::word_t rdata;

	modport cpu (output addr, wdata, read, write, input rdata);

	modport mem (input addr, wdata, read, write, output rdata);

endinterface

`default_nettype wire

/* design/reg_file.sv */
`default_nettype none

module reg_file (
	input wire logic clk,
	input wire logic reset,
	input wire logic write_en,
	input wire cpu16_pkg::reg_idx_t ra_idx,
	input wire cpu16_pkg::reg_idx_t rb_idx,
	input wire cpu16_pkg::word_t write_data,
	output cpu16_pkg::word_t ra_data,
	output cpu16_pkg::word_t rb_data
);

	cpu16_pkg::word_t regs [cpu16_pkg::REG_COUNT];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			regs <= cpu16_pkg::REG_RESET;
		end
		else if (write_en)
		begin
			regs[ra_idx] <= write_data; // ra is also the destination
		end
	end

	assign ra_data = regs[ra_idx];
	assign rb_data = regs[rb_idx];

endmodule

`default_nettype wire

/* design/alu.sv */
`default_nettype none

module alu (
	input wire cpu16_pkg::alu_op_t op,
	input wire cpu16_pkg::word_t a,
	input wire cpu16_pkg::word_t b,
	output cpu16_pkg::word_t result,
	output logic zero
);

	always_comb
	begin
		case (op)
			cpu16_pkg::ALU_ADD: result = a + b;
			cpu16_pkg::ALU_SUB: result = a - b;
			cpu16_pkg::ALU_OR: result = a | b;
			default: result = a + b;
		endcase
	end

	assign zero = (result == '0); // bne takes the branch when low

endmodule

`default_nettype wire

/* design/ctrl_fsm.sv */
`default_nettype none

module ctrl_fsm (
	input wire logic clk,
	input wire logic reset,
	input wire logic run,
	cpu_ctrl_if.ctrl ctrl,
	output logic halted,
	output logic host_grant
);

	cpu16_pkg::cpu_state_t state;
	cpu16_pkg::cpu_state_t state_next;

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= cpu16_pkg::S_IDLE;
		else
			state <= state_next;
	end

	always_comb
	begin
		state_next = state;
		ctrl.pc_write = 1'b0;
		ctrl.ir_write = 1'b0;
		ctrl.i_or_d = 1'b0;
		ctrl.mem_read = 1'b0;
		ctrl.mem_write = 1'b0;
		ctrl.reg_write = 1'b0;
		ctrl.alu_op = cpu16_pkg::ALU_ADD;
		ctrl.a_sel = cpu16_pkg::SRC_A_PC;
		ctrl.b_sel = cpu16_pkg::SRC_B_TWO;
		ctrl.pc_src = cpu16_pkg::PC_ALU;
		ctrl.wb_sel = cpu16_pkg::WB_ALU;
		ctrl.branch = 1'b0;

		case (state)
			cpu16_pkg::S_IDLE:
			begin
				if (run)
				begin
					ctrl.pc_write = 1'b1; // start at address 0
					ctrl.pc_src = cpu16_pkg::PC_ZERO;
					state_next = cpu16_pkg::S_FETCH;
				end
			end
			cpu16_pkg::S_FETCH:
			begin
				ctrl.mem_read = 1'b1;
				ctrl.ir_write = 1'b1;
				ctrl.pc_write = 1'b1; // pc + 2
				state_next = cpu16_pkg::S_DECODE;
			end
			cpu16_pkg::S_DECODE:
			begin
				ctrl.b_sel = cpu16_pkg::SRC_B_BOFF; // branch target into alu-out
				case (ctrl.opcode)
					cpu16_pkg::OP_RTYPE, cpu16_pkg::OP_ORI, cpu16_pkg::OP_LW,
					cpu16_pkg::OP_SW, cpu16_pkg::OP_BNE:
						state_next = cpu16_pkg::S_EXEC;
					cpu16_pkg::OP_HALT:
						state_next = cpu16_pkg::S_HALTED;
					default:
						state_next = cpu16_pkg::S_HALTED; // unknown opcode stops too
				endcase
			end
			cpu16_pkg::S_EXEC:
			begin
				ctrl.a_sel = cpu16_pkg::SRC_A_REG;
				ctrl.b_sel = cpu16_pkg::SRC_B_REG;
				state_next = cpu16_pkg::S_MEMWB;
				case (ctrl.opcode)
					cpu16_pkg::OP_RTYPE:
					begin
						if (ctrl.func == cpu16_pkg::FN_SUB)
							ctrl.alu_op = cpu16_pkg::ALU_SUB;
					end
					cpu16_pkg::OP_ORI:
					begin
						ctrl.a_sel = cpu16_pkg::SRC_A_ZEXT;
						ctrl.alu_op = cpu16_pkg::ALU_OR;
					end
					cpu16_pkg::OP_LW, cpu16_pkg::OP_SW:
						ctrl.a_sel = cpu16_pkg::SRC_A_SEXT; // rb + offset
					cpu16_pkg::OP_BNE:
					begin
						ctrl.alu_op = cpu16_pkg::ALU_SUB;
						ctrl.branch = 1'b1;
						ctrl.pc_write = 1'b1; // gated by not-zero in datapath
						ctrl.pc_src = cpu16_pkg::PC_BRANCH;
						state_next = cpu16_pkg::S_FETCH;
					end
					default:
						state_next = cpu16_pkg::S_HALTED;
				endcase
			end
			cpu16_pkg::S_MEMWB:
			begin
				state_next = cpu16_pkg::S_FETCH;
				case (ctrl.opcode)
					cpu16_pkg::OP_LW:
					begin
						ctrl.i_or_d = 1'b1;
						ctrl.mem_read = 1'b1;
						state_next = cpu16_pkg::S_LOADWB;
					end
					cpu16_pkg::OP_SW:
					begin
						ctrl.i_or_d = 1'b1;
						ctrl.mem_write = 1'b1;
					end
					cpu16_pkg::OP_RTYPE:
						ctrl.reg_write = (ctrl.func == cpu16_pkg::FN_ADD) ||
							(ctrl.func == cpu16_pkg::FN_SUB);
					default:
						ctrl.reg_write = 1'b1; // ori
				endcase
			end
			cpu16_pkg::S_LOADWB:
			begin
				ctrl.reg_write = 1'b1;
				ctrl.wb_sel = cpu16_pkg::WB_MEM;
				state_next = cpu16_pkg::S_FETCH;
			end
			cpu16_pkg::S_HALTED:
			begin
				if (!run)
					state_next = cpu16_pkg::S_IDLE;
			end
			default:
				state_next = cpu16_pkg::S_IDLE;
		endcase
	end

	assign halted = (state == cpu16_pkg::S_HALTED);
	assign host_grant = (state == cpu16_pkg::S_IDLE) || (state == cpu16_pkg::S_HALTED);

endmodule

`default_nettype wire

/* design/datapath.sv */
`default_nettype none

module datapath (
	input wire logic clk,
	input wire logic reset,
	cpu_ctrl_if.dp ctrl,
	mem_bus_if.cpu mem
);

	localparam int EXT_W = cpu16_pkg::DATA_W - cpu16_pkg::IMM_W;

	cpu16_pkg::word_t pc, pc_next;
	cpu16_pkg::word_t ir;
	cpu16_pkg::word_t mdr;
	cpu16_pkg::word_t a_reg, b_reg, alu_out;
	cpu16_pkg::word_t ra_data, rb_data;
	cpu16_pkg::word_t alu_a, alu_b, alu_result;
	cpu16_pkg::word_t sext_imm, zext_imm, boff;
	cpu16_pkg::word_t wb_data;
	logic [cpu16_pkg::IMM_W-1:0] imm;
	logic pc_en;

	assign imm = ir[cpu16_pkg::IMM_LSB +: cpu16_pkg::IMM_W];
	assign sext_imm = {{EXT_W{imm[cpu16_pkg::IMM_W-1]}}, imm};
	assign zext_imm = {{EXT_W{1'b0}}, imm};
	assign boff = {sext_imm[cpu16_pkg::DATA_W-2:0], 1'b0}; // word offset to bytes

	assign ctrl.opcode = cpu16_pkg::opcode_t'(ir[cpu16_pkg::OPC_LSB +: $bits(cpu16_pkg::opcode_t)]);
	assign ctrl.func = cpu16_pkg::func_t'(ir[cpu16_pkg::FUNC_LSB +: $bits(cpu16_pkg::func_t)]);

	always_ff @(posedge clk)
	begin
		if (reset)
			pc <= '0;
		else if (pc_en)
			pc <= pc_next;
	end

	always_ff @(posedge clk)
	begin
		if (ctrl.ir_write)
			ir <= mem.rdata;
		mdr <= mem.rdata;
		a_reg <= ra_data;
		b_reg <= rb_data;
		alu_out <= alu_result;
	end

	reg_file u_reg_file (
		.clk(clk),
		.reset(reset),
		.write_en(ctrl.reg_write),
		.ra_idx(ir[cpu16_pkg::RA_LSB +: $bits(cpu16_pkg::reg_idx_t)]),
		.rb_idx(ir[cpu16_pkg::RB_LSB +: $bits(cpu16_pkg::reg_idx_t)]),
		.write_data(wb_data),
		.ra_data(ra_data),
		.rb_data(rb_data)
	);

	always_comb
	begin
		case (ctrl.a_sel)
			cpu16_pkg::SRC_A_PC: alu_a = pc;
			cpu16_pkg::SRC_A_REG: alu_a = a_reg;
			cpu16_pkg::SRC_A_SEXT: alu_a = sext_imm;
			default: alu_a = zext_imm;
		endcase
		case (ctrl.b_sel)
			cpu16_pkg::SRC_B_REG: alu_b = b_reg;
			cpu16_pkg::SRC_B_TWO: alu_b = 16'd2;
			default: alu_b = boff;
		endcase
		case (ctrl.pc_src)
			cpu16_pkg::PC_ALU: pc_next = alu_result;
			cpu16_pkg::PC_BRANCH: pc_next = alu_out; // target from decode
			default: pc_next = '0;
		endcase
	end

	alu u_alu (
		.op(ctrl.alu_op),
		.a(alu_a),
		.b(alu_b),
		.result(alu_result),
		.zero(ctrl.zero)
	);

	assign pc_en = ctrl.pc_write && (!ctrl.branch || !ctrl.zero);
	assign wb_data = (ctrl.wb_sel == cpu16_pkg::WB_MEM) ? mdr : alu_out;

	assign mem.addr = ctrl.i_or_d ? alu_out : pc;
	assign mem.wdata = a_reg; // store data from ra
	assign mem.read = ctrl.mem_read;
	assign mem.write = ctrl.mem_write;

endmodule

`default_nettype wire

/* design/unified_mem.sv */
`default_nettype none

module unified_mem (
	input wire logic clk,
	input wire logic reset,
	input wire logic host_grant,
	input wire logic host_req,
	input wire logic host_we,
	input wire cpu16_pkg::mem_idx_t host_addr,
	input wire cpu16_pkg::word_t host_wdata,
	output logic host_ack,
	output cpu16_pkg::word_t host_rdata,
	mem_bus_if.mem bus
);

	cpu16_pkg::word_t mem [cpu16_pkg::MEM_WORDS];
	cpu16_pkg::mem_idx_t cpu_idx;
	logic host_take;

	assign cpu_idx = bus.addr[1 +: $bits(cpu16_pkg::mem_idx_t)]; // bit 0 ignored
	assign bus.rdata = bus.read ? mem[cpu_idx] : '0;

	// new request seen while the cpu is stopped
	assign host_take = host_req && host_grant && !host_ack;

	always_ff @(posedge clk)
	begin
		if (bus.write)
			mem[cpu_idx] <= bus.wdata;
		else if (host_take && host_we)
			mem[host_addr] <= host_wdata;
	end

	always_ff @(posedge clk)
	begin
		if (host_take && !host_we)
			host_rdata <= mem[host_addr];
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			host_ack <= 1'b0;
		else if (host_take)
			host_ack <= 1'b1;
		else if (!host_req)
			host_ack <= 1'b0; // held until req drops
	end

endmodule

`default_nettype wire

/* design/multi_cycle_cpu.sv */
`default_nettype none

module multi_cycle_cpu (
	input wire logic clk,
	input wire logic reset,
	input wire logic run,
	input wire logic host_req,
	input wire logic host_we,
	input wire cpu16_pkg::mem_idx_t host_addr,
	input wire cpu16_pkg::word_t host_wdata,
	output logic halted,
	output logic host_ack,
	output cpu16_pkg::word_t host_rdata
);

	logic host_grant;

	cpu_ctrl_if ctrl_bus ();
	mem_bus_if mem_bus ();

	ctrl_fsm u_ctrl_fsm (
		.clk(clk),
		.reset(reset),
		.run(run),
		.ctrl(ctrl_bus.ctrl),
		.halted(halted),
		.host_grant(host_grant)
	);

	datapath u_datapath (
		.clk(clk),
		.reset(reset),
		.ctrl(ctrl_bus.dp),
		.mem(mem_bus.cpu)
	);

	unified_mem u_unified_mem (
		.clk(clk),
		.reset(reset),
		.host_grant(host_grant),
		.host_req(host_req),
		.host_we(host_we),
		.host_addr(host_addr),
		.host_wdata(host_wdata),
		.host_ack(host_ack),
		.host_rdata(host_rdata),
		.bus(mem_bus.mem)
	);

endmodule

`default_nettype wire

/* include/tb_cases.svh */
`ifndef TB_CASES_SVH
`define TB_CASES_SVH

// every program starts at word 0 with the registers at their reset values
localparam int NUM_CASES = 7;

string case_name [NUM_CASES];
cpu16_pkg::word_t case_prog [NUM_CASES][PROG_WORDS];
logic case_preload [NUM_CASES];
cpu16_pkg::mem_idx_t case_data_addr [NUM_CASES];
cpu16_pkg::word_t case_data_val [NUM_CASES];
cpu16_pkg::mem_idx_t case_chk_addr [NUM_CASES];
cpu16_pkg::word_t case_expect [NUM_CASES];
logic case_backpressure [NUM_CASES];
int case_cycles [NUM_CASES]; // instruction cycles including halt

task automatic define_case(input int idx, input string name, input cpu16_pkg::mem_idx_t chk,
	input cpu16_pkg::word_t exp, input int cyc);
	case_name[idx] = name;
	case_chk_addr[idx] = chk;
	case_expect[idx] = exp;
	case_cycles[idx] = cyc;
	case_preload[idx] = 1'b0;
	case_data_addr[idx] = '0;
	case_data_val[idx] = '0;
	case_backpressure[idx] = 1'b0;
	for (int k = 0; k < PROG_WORDS; k++)
		case_prog[idx][k] = enc_imm(cpu16_pkg::OP_HALT, 0, 0, 0); // unused slots halt
endtask

task automatic fill_case_table();
	define_case(0, "add_sw", 6'd16, cpu16_pkg::REG_RESET[1] + cpu16_pkg::REG_RESET[2], 10);
	case_prog[0][0] = enc_rtype(cpu16_pkg::FN_ADD, 1, 2);
	case_prog[0][1] = enc_imm(cpu16_pkg::OP_SW, 1, 3, 0); // r3 = 32, word 16

	define_case(1, "sub_sw", 6'd12, cpu16_pkg::REG_RESET[4] - cpu16_pkg::REG_RESET[5], 10);
	case_prog[1][0] = enc_rtype(cpu16_pkg::FN_SUB, 4, 5); // wraps below zero
	case_prog[1][1] = enc_imm(cpu16_pkg::OP_SW, 4, 2, 4); // 20 + 4, word 12

	define_case(2, "ori_zext", 6'd17, cpu16_pkg::REG_RESET[4] | 16'h003a, 10);
	case_prog[2][0] = enc_imm(cpu16_pkg::OP_ORI, 4, 4, 'h3a); // imm msb set
	case_prog[2][1] = enc_imm(cpu16_pkg::OP_SW, 4, 3, 2);

	define_case(3, "lw_neg_offset", 6'd16, 16'h0100 + cpu16_pkg::REG_RESET[0], 15);
	case_preload[3] = 1'b1;
	case_data_addr[3] = 6'd12; // 32 - 8 = byte 24
	case_data_val[3] = 16'h0100;
	case_prog[3][0] = enc_imm(cpu16_pkg::OP_LW, 1, 3, -8);
	case_prog[3][1] = enc_rtype(cpu16_pkg::FN_ADD, 1, 0);
	case_prog[3][2] = enc_imm(cpu16_pkg::OP_SW, 1, 3, 0);

	define_case(4, "bne_taken", 6'd16, cpu16_pkg::REG_RESET[2], 9);
	case_prog[4][0] = enc_imm(cpu16_pkg::OP_BNE, 0, 1, 1); // 7 != 8, skip word 1
	case_prog[4][2] = enc_imm(cpu16_pkg::OP_SW, 2, 3, 0);

	define_case(5, "bne_not_taken", 6'd16, cpu16_pkg::REG_RESET[5], 9);
	case_prog[5][0] = enc_imm(cpu16_pkg::OP_BNE, 4, 6, 1); // 1 == 1, falls through
	case_prog[5][1] = enc_imm(cpu16_pkg::OP_SW, 5, 3, 0);

	define_case(6, "host_backpressure", 6'd19, cpu16_pkg::REG_RESET[0] +
		cpu16_pkg::REG_RESET[1] + cpu16_pkg::REG_RESET[2], 14);
	case_backpressure[6] = 1'b1;
	case_prog[6][0] = enc_rtype(cpu16_pkg::FN_ADD, 0, 1);
	case_prog[6][1] = enc_rtype(cpu16_pkg::FN_ADD, 0, 2);
	case_prog[6][2] = enc_imm(cpu16_pkg::OP_SW, 0, 3, 6); // byte 38, word 19
endtask

`endif

/* verif/multi_cycle_cpu_tb.sv */
`default_nettype none

module multi_cycle_cpu_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_HALF = 10;
	localparam int DRIVE_DLY = 2;
	localparam int RESET_CYCLES = 8;
	localparam int PROG_WORDS = 8;
	localparam int HOST_CYCLES = 6; // req, ack, hold, release with margin
	localparam int HOST_PER_CASE = PROG_WORDS + 3;
	localparam int CASE_SLACK = 8;

	logic clk;
	logic reset;
	logic run;
	logic host_req;
	logic host_we;
	cpu16_pkg::mem_idx_t host_addr;
	cpu16_pkg::word_t host_wdata;
	logic halted;
	logic host_ack;
	cpu16_pkg::word_t host_rdata;

	int cycles;
	int cycle_limit;
	int errors;
	int pass_count;
	int fail_count;
	string current_test;

	function automatic cpu16_pkg::word_t enc_rtype(cpu16_pkg::func_t fn, int ra, int rb);
		cpu16_pkg::word_t w;
		w = '0;
		w[cpu16_pkg::OPC_LSB +: 4] = cpu16_pkg::OP_RTYPE;
		w[cpu16_pkg::RA_LSB +: 3] = ra[2:0];
		w[cpu16_pkg::RB_LSB +: 3] = rb[2:0];
		w[cpu16_pkg::FUNC_LSB +: 3] = fn;
		return w;
	endfunction

	function automatic cpu16_pkg::word_t enc_imm(cpu16_pkg::opcode_t op, int ra, int rb,
		int imm);
		cpu16_pkg::word_t w;
		w = '0;
		w[cpu16_pkg::OPC_LSB +: 4] = op;
		w[cpu16_pkg::RA_LSB +: 3] = ra[2:0];
		w[cpu16_pkg::RB_LSB +: 3] = rb[2:0];
		w[cpu16_pkg::IMM_LSB +: cpu16_pkg::IMM_W] = imm[cpu16_pkg::IMM_W-1:0];
		return w;
	endfunction

	`include "tb_cases.svh"

	multi_cycle_cpu i_dut (
		.clk(clk),
		.reset(reset),
		.run(run),
		.host_req(host_req),
		.host_we(host_we),
		.host_addr(host_addr),
		.host_wdata(host_wdata),
		.halted(halted),
		.host_ack(host_ack),
		.host_rdata(host_rdata)
	);

	initial
	begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (cycles > cycle_limit)
		begin
			$display("TIMEOUT: test %s did not finish within %0d cycles", current_test,
				cycle_limit);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	task automatic tick();
		@(posedge clk);
		#DRIVE_DLY;
	endtask

	task automatic reset_dut();
		reset = 1'b1;
		repeat (RESET_CYCLES) tick();
		reset = 1'b0;
		tick();
	endtask

	task automatic begin_host(input logic we, input cpu16_pkg::mem_idx_t addr,
		input cpu16_pkg::word_t wdata);
		host_we = we;
		host_addr = addr;
		host_wdata = wdata;
		host_req = 1'b1;
	endtask

	task automatic finish_host(output cpu16_pkg::word_t rdata);
		tick();
		while (!host_ack)
			tick();
		rdata = host_rdata;
		tick(); // req held one more clock
		assert (host_ack) else
		begin
			$display("ERROR %s: host_ack fell while host_req was still high", current_test);
			errors++;
		end
		host_req = 1'b0;
		tick();
		assert (!host_ack) else
		begin
			$display("ERROR %s: host_ack still high a clock after host_req fell", current_test);
			errors++;
		end
		while (host_ack)
			tick();
	endtask

	task automatic host_access(input logic we, input cpu16_pkg::mem_idx_t addr,
		input cpu16_pkg::word_t wdata, output cpu16_pkg::word_t rdata);
		begin_host(we, addr, wdata);
		finish_host(rdata);
	endtask

	function automatic cpu16_pkg::word_t fill_word(cpu16_pkg::mem_idx_t addr);
		return 16'h5a00 | {10'd0, addr};
	endfunction

	task automatic check_word(input cpu16_pkg::word_t expected, input cpu16_pkg::word_t actual);
		assert (actual === expected) else
		begin
			$display("MISMATCH %s: expected %h actual %h", current_test, expected, actual);
			errors++;
		end
	endtask

	task automatic report_test();
		if (errors == 0)
		begin
			pass_count++;
			$display("PASS %s", current_test);
		end
		else
		begin
			fail_count++;
			$display("FAIL %s (%0d errors)", current_test, errors);
		end
	endtask

	task automatic check_host_port();
		cpu16_pkg::word_t rd;
		current_test = "host_rw";
		errors = 0;
		reset_dut();
		assert (!halted && !host_ack) else
		begin
			$display("ERROR %s: halted or host_ack high after reset", current_test);
			errors++;
		end
		host_access(1'b1, 6'd40, 16'hbeef, rd);
		host_access(1'b1, 6'd63, 16'h1357, rd);
		host_access(1'b0, 6'd40, '0, rd);
		check_word(16'hbeef, rd);
		host_access(1'b0, 6'd63, '0, rd);
		check_word(16'h1357, rd);
		report_test();
	endtask

	task automatic run_case(input int idx);
		cpu16_pkg::word_t rd;
		current_test = case_name[idx];
		errors = 0;
		reset_dut();
		for (int k = 0; k < PROG_WORDS; k++)
			host_access(1'b1, k[5:0], case_prog[idx][k], rd);
		if (case_preload[idx])
			host_access(1'b1, case_data_addr[idx], case_data_val[idx], rd);
		host_access(1'b1, case_chk_addr[idx], fill_word(case_chk_addr[idx]), rd);
		run = 1'b1;
		tick();
		if (case_backpressure[idx])
			begin_host(1'b0, case_chk_addr[idx], '0); // must wait for the halt
		while (!halted)
		begin
			assert (!host_ack) else
			begin
				$display("ERROR %s: host_ack high while the processor runs", current_test);
				errors++;
			end
			tick();
		end
		run = 1'b0;
		if (case_backpressure[idx])
			finish_host(rd);
		else
			host_access(1'b0, case_chk_addr[idx], '0, rd);
		check_word(case_expect[idx], rd);
		assert (!halted) else
		begin
			$display("ERROR %s: halted still high after run was lowered", current_test);
			errors++;
		end
		report_test();
	endtask

	initial
	begin
		reset = 1'b1;
		run = 1'b0;
		host_req = 1'b0;
		host_we = 1'b0;
		host_addr = '0;
		host_wdata = '0;
		cycles = 0;
		errors = 0;
		pass_count = 0;
		fail_count = 0;
		current_test = "setup";
		fill_case_table();
		cycle_limit = RESET_CYCLES + 4 * HOST_CYCLES + CASE_SLACK;
		for (int i = 0; i < NUM_CASES; i++)
			cycle_limit += case_cycles[i] + RESET_CYCLES + HOST_PER_CASE * HOST_CYCLES +
				CASE_SLACK;
		check_host_port();
		for (int i = 0; i < NUM_CASES; i++)
			run_case(i);
		$display("tests: %0d passed, %0d failed", pass_count, fail_count);
		if (fail_count == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* multi_cycle_cpu.f */
+incdir+include
design/cpu16_pkg.sv
design/cpu_ctrl_if.sv
design/mem_bus_if.sv
design/reg_file.sv
design/alu.sv
design/ctrl_fsm.sv
design/datapath.sv
design/unified_mem.sv
design/multi_cycle_cpu.sv
verif/multi_cycle_cpu_tb.sv

/* Bender.yml */
package:
  name: multi_cycle_cpu

sources:
  - files:
      - design/cpu16_pkg.sv
      - design/cpu_ctrl_if.sv
      - design/mem_bus_if.sv
      - design/reg_file.sv
      - design/alu.sv
      - design/ctrl_fsm.sv
      - design/datapath.sv
      - design/unified_mem.sv
      - design/multi_cycle_cpu.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verif/multi_cycle_cpu_tb.sv
